// ==== filelist.f ====
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_writeback.sv
rtl/processor.sv
verif/processor_props.sv
verif/processor_tb.sv

// ==== rtl/alu.sv ====
// Combinational ALU for add, sub, and, or, sll and sra
// Not-equal and signed less-than flags from the subtraction
`default_nettype none

module alu import cpu_pkg::*; (
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_e alu_op,
    input  shamt_t  shamt,
    output word_t   result,
    output logic    not_equal,
    output logic    less_than
);

    word_t sum;
    word_t diff;
    logic  sub_ovf;

    assign sum  = operand_a + operand_b;
    assign diff = operand_a - operand_b;

    // Signed overflow of a - b, operands of opposite sign
    assign sub_ovf = (operand_a[31] != operand_b[31]) && (diff[31] != operand_a[31]);

    // ----------------------------------------------------------
    // Flags, always from the subtraction
    // ----------------------------------------------------------
    assign not_equal = (diff != '0);
    assign less_than = diff[31] ^ sub_ovf;  // Sign corrected for overflow

    always_comb begin
        case (alu_op)
            alu_add: result = sum;
            alu_sub: result = diff;
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_sll: result = operand_a << shamt;
            alu_sra: result = word_t'($signed(operand_a) >>> shamt);  // Keeps sign
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
// Shared types, instruction field positions and encodings for the pipeline
// Opcode and ALU-op enums, reset values
`default_nettype none

package cpu_pkg;

    // ----------------------------------------------------------
    // Widths that carry a meaning
    // ----------------------------------------------------------
    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  reg_idx_t;  // Register number
    typedef logic [16:0] imm_t;      // I-type immediate
    typedef logic [4:0]  shamt_t;    // Shift amount

    // ----------------------------------------------------------
    // Instruction field positions
    // ----------------------------------------------------------
    localparam int opcode_msb   = 31;
    localparam int opcode_lsb   = 27;
    localparam int rd_lsb       = 22;  // rd in [26:22]
    localparam int rs_lsb       = 17;  // rs in [21:17]
    localparam int rt_lsb       = 12;  // rt in [16:12]
    localparam int shamt_lsb    = 7;
    localparam int aluop_lsb    = 2;
    localparam int imm_width    = 17;  // Low bits of the word
    localparam int target_width = 27;  // J-type target, low bits

    // Opcode field encodings
    typedef enum logic [4:0] {
        op_rtype = 5'b00000,
        op_j     = 5'b00001,
        op_bne   = 5'b00010,
        op_jal   = 5'b00011,
        op_jr    = 5'b00100,
        op_addi  = 5'b00101,
        op_blt   = 5'b00110,
        op_sw    = 5'b00111,
        op_lw    = 5'b01000
    } opcode_e;

    // ALU operation, also the R-type aluop field
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    localparam reg_idx_t link_reg = 5'd31;      // jal destination
    localparam word_t    reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// Decode stage with field split, control decode and register read select
// RAW interlock against execute, memory and writeback, plus the D/X register
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire      clock,
    input  wire      reset,
    input  word_t    fd_instr,
    input  word_t    fd_pc_plus1,
    input  wire      fd_valid,
    input  wire      redirect,       // Squash the instr in decode
    input  word_t    data_readRegA,
    input  word_t    data_readRegB,
    input  reg_idx_t dx_hold_dest,   // Dest of the instr now in execute
    input  reg_idx_t xm_dest,
    input  reg_idx_t mw_dest,
    input  wire      xm_reg_write,
    input  wire      mw_reg_write,
    output logic     stall,
    output reg_idx_t ctrl_readRegA,
    output reg_idx_t ctrl_readRegB,
    output logic     dx_valid,
    output opcode_e  dx_op,
    output alu_op_e  dx_alu_op,
    output logic     dx_use_imm,
    output logic     dx_reg_write,
    output logic     dx_mem_write,
    output logic     dx_mem_to_reg,
    output reg_idx_t dx_dest,
    output shamt_t   dx_shamt,
    output word_t    dx_a,
    output word_t    dx_b,
    output word_t    dx_imm,
    output word_t    dx_target,
    output word_t    dx_pc_plus1
);

    // ----------------------------------------------------------
    // Field extraction
    // ----------------------------------------------------------
    opcode_e                 op;
    reg_idx_t                rd, rs, rt;
    shamt_t                  shamt;
    alu_op_e                 aluop_field;
    imm_t                    imm;
    logic [target_width-1:0] target;

    assign op          = opcode_e'(fd_instr[opcode_msb:opcode_lsb]);
    assign rd          = fd_instr[rd_lsb +: $bits(reg_idx_t)];
    assign rs          = fd_instr[rs_lsb +: $bits(reg_idx_t)];
    assign rt          = fd_instr[rt_lsb +: $bits(reg_idx_t)];
    assign shamt       = fd_instr[shamt_lsb +: $bits(shamt_t)];
    assign aluop_field = alu_op_e'(fd_instr[aluop_lsb +: $bits(alu_op_e)]);
    assign imm         = fd_instr[imm_width-1:0];
    assign target      = fd_instr[target_width-1:0];

    // Control levels for the instr in decode
    alu_op_e  alu_op_dec;
    reg_idx_t dest_dec;
    logic     use_imm_dec, reg_write_raw, mem_write_dec, mem_to_reg_dec;
    logic     use_a, use_b;   // Which read ports carry a real source
    logic     reg_write_dec;
    logic     load_dx;

    always_comb begin
        alu_op_dec     = alu_add;
        dest_dec       = rd;
        use_imm_dec    = 1'b0;
        reg_write_raw  = 1'b0;
        mem_write_dec  = 1'b0;
        mem_to_reg_dec = 1'b0;
        use_a          = 1'b0;
        use_b          = 1'b0;
        ctrl_readRegA  = rs;
        ctrl_readRegB  = rt;
        case (op)
            op_rtype: begin
                alu_op_dec    = aluop_field;
                reg_write_raw = 1'b1;
                use_a         = 1'b1;
                use_b         = 1'b1;
            end
            op_addi, op_lw: begin
                use_imm_dec    = 1'b1;
                reg_write_raw  = 1'b1;
                mem_to_reg_dec = (op == op_lw);
                use_a          = 1'b1;
            end
            op_sw: begin
                use_imm_dec   = 1'b1;
                mem_write_dec = 1'b1;
                ctrl_readRegB = rd;    // Store data comes from rd
                use_a         = 1'b1;
                use_b         = 1'b1;
            end
            op_bne, op_blt: begin
                alu_op_dec    = alu_sub;  // Flags compare rd against rs
                ctrl_readRegA = rd;
                ctrl_readRegB = rs;
                use_a         = 1'b1;
                use_b         = 1'b1;
            end
            op_jr: begin
                ctrl_readRegA = rd;    // Target register
                use_a         = 1'b1;
            end
            op_jal: begin
                dest_dec      = link_reg;
                reg_write_raw = 1'b1;
            end
            op_j:    ;                 // Target only, no register use
            default: ;                 // Unknown opcode acts as a nop
        endcase
    end

    assign reg_write_dec = reg_write_raw && (dest_dec != '0);  // r0 stays zero

    // ----------------------------------------------------------
    // RAW interlock
    // ----------------------------------------------------------
    // Write flags are zero for bubbles and for r0, so no extra checks
    function automatic logic pending(input reg_idx_t src);
        pending = (dx_reg_write && src == dx_hold_dest)
               || (xm_reg_write && src == xm_dest)
               || (mw_reg_write && src == mw_dest);
    endfunction

    assign stall = fd_valid && ((use_a && pending(ctrl_readRegA))
                             || (use_b && pending(ctrl_readRegB)));

    assign load_dx = fd_valid && !stall && !redirect;  // Else a bubble

    // D/X register
    always_ff @(posedge clock) begin
        if (reset) begin
            dx_valid     <= 1'b0;
            dx_reg_write <= 1'b0;
            dx_mem_write <= 1'b0;
        end else begin
            dx_valid     <= load_dx;
            dx_reg_write <= load_dx && reg_write_dec;
            dx_mem_write <= load_dx && mem_write_dec;
        end
    end

    always_ff @(posedge clock) begin
        dx_op         <= op;
        dx_alu_op     <= alu_op_dec;
        dx_use_imm    <= use_imm_dec;
        dx_mem_to_reg <= mem_to_reg_dec;
        dx_dest       <= dest_dec;
        dx_shamt      <= shamt;
        dx_a          <= data_readRegA;
        dx_b          <= data_readRegB;
        dx_imm        <= {{($bits(word_t) - imm_width){imm[imm_width-1]}}, imm};  // Sign ext
        dx_target     <= {{($bits(word_t) - target_width){1'b0}}, target};       // Zero ext
        dx_pc_plus1   <= fd_pc_plus1;
    end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// Execute stage with operand select, branch and jump resolution
// Link value for jal and the X/M pipeline register
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire      clock,
    input  wire      reset,
    input  logic     dx_valid,
    input  opcode_e  dx_op,
    input  alu_op_e  dx_alu_op,
    input  logic     dx_use_imm,
    input  logic     dx_reg_write,
    input  logic     dx_mem_write,
    input  logic     dx_mem_to_reg,
    input  reg_idx_t dx_dest,
    input  shamt_t   dx_shamt,
    input  word_t    dx_a,
    input  word_t    dx_b,
    input  word_t    dx_imm,
    input  word_t    dx_target,
    input  word_t    dx_pc_plus1,
    output logic     redirect,
    output word_t    redirect_pc,
    output word_t    xm_result,
    output word_t    xm_store_data,
    output reg_idx_t xm_dest,
    output logic     xm_reg_write,
    output logic     xm_mem_write,
    output logic     xm_mem_to_reg
);

    word_t alu_b;
    word_t alu_result;
    word_t branch_target;
    logic  not_equal, less_than;
    logic  taken, is_jump;

    assign alu_b = dx_use_imm ? dx_imm : dx_b;

    alu u_alu (
        .operand_a (dx_a),
        .operand_b (alu_b),
        .alu_op    (dx_alu_op),
        .shamt     (dx_shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // ----------------------------------------------------------
    // Branch and jump resolution
    // ----------------------------------------------------------
    assign taken   = dx_valid && ((dx_op == op_bne && not_equal)
                               || (dx_op == op_blt && less_than));  // rd < rs
    assign is_jump = dx_valid && (dx_op == op_j || dx_op == op_jal || dx_op == op_jr);

    assign redirect      = taken || is_jump;  // Predicted not taken
    assign branch_target = dx_pc_plus1 + dx_imm;

    always_comb begin
        case (dx_op)
            op_jr:        redirect_pc = dx_a;       // Register target
            op_j, op_jal: redirect_pc = dx_target;
            default:      redirect_pc = branch_target;
        endcase
    end

    // X/M register, dest already r31 for jal
    always_ff @(posedge clock) begin
        if (reset) begin
            xm_reg_write  <= 1'b0;
            xm_mem_write  <= 1'b0;
            xm_mem_to_reg <= 1'b0;
        end else begin
            xm_reg_write  <= dx_reg_write;   // Valid already folded in
            xm_mem_write  <= dx_mem_write;
            xm_mem_to_reg <= dx_mem_to_reg;
        end
    end

    always_ff @(posedge clock) begin
        xm_result     <= (dx_op == op_jal) ? dx_pc_plus1 : alu_result;  // Link value
        xm_store_data <= dx_b;
        xm_dest       <= dx_dest;
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// Fetch stage with the PC register and next-PC select
// Fetch/decode pipeline register with stall hold and redirect squash
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  wire   clock,
    input  wire   reset,
    input  wire   stall,         // Decode interlock, hold PC and F/D
    input  wire   redirect,      // Taken branch or jump in execute
    input  word_t redirect_pc,
    input  word_t q_imem,
    output word_t address_imem,
    output word_t fd_instr,
    output word_t fd_pc_plus1,
    output logic  fd_valid
);

    word_t pc;
    word_t pc_plus1;

    assign pc_plus1     = pc + word_t'(1);
    assign address_imem = pc;  // Imem is combinational

    // PC, redirect wins over stall
    always_ff @(posedge clock) begin
        if (reset)         pc <= reset_pc;
        else if (redirect) pc <= redirect_pc;
        else if (!stall)   pc <= pc_plus1;
    end

    // ----------------------------------------------------------
    // F/D register
    // ----------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset)         fd_valid <= 1'b0;
        else if (redirect) fd_valid <= 1'b0;  // Squash younger instr
        else if (!stall)   fd_valid <= 1'b1;
    end

    always_ff @(posedge clock) begin
        if (!stall) begin          // Hold word while decode waits
            fd_instr    <= q_imem;
            fd_pc_plus1 <= pc_plus1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/memory_writeback.sv ====
// Memory stage drive of data memory, M/W register and writeback mux
`default_nettype none

module memory_writeback import cpu_pkg::*; (
    input  wire      clock,
    input  wire      reset,
    input  word_t    xm_result,
    input  word_t    xm_store_data,
    input  reg_idx_t xm_dest,
    input  logic     xm_reg_write,
    input  logic     xm_mem_write,
    input  logic     xm_mem_to_reg,
    input  word_t    q_dmem,
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    output reg_idx_t mw_dest,
    output logic     mw_reg_write,
    output logic     ctrl_writeEnable,
    output reg_idx_t ctrl_writeReg,
    output word_t    data_writeReg
);

    word_t mw_result;
    word_t mw_load;
    logic  mw_mem_to_reg;

    // Dmem is combinational, read data valid this cycle
    assign address_dmem = xm_result;
    assign data         = xm_store_data;
    assign wren         = xm_mem_write;

    // ----------------------------------------------------------
    // M/W register
    // ----------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            mw_reg_write  <= 1'b0;
            mw_mem_to_reg <= 1'b0;
        end else begin
            mw_reg_write  <= xm_reg_write;
            mw_mem_to_reg <= xm_mem_to_reg;
        end
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load   <= q_dmem;
        mw_dest   <= xm_dest;
    end

    // Register file writes at the next rising edge
    assign ctrl_writeEnable = mw_reg_write;
    assign ctrl_writeReg    = mw_dest;
    assign data_writeReg    = mw_mem_to_reg ? mw_load : mw_result;

endmodule

`default_nettype wire

// ==== rtl/processor.sv ====
// Five-stage pipeline top level
// Instruction memory, data memory and register file are reached through ports
`default_nettype none

module processor import cpu_pkg::*; (
    input  wire      clock,
    input  wire      reset,
    output word_t    address_imem,
    input  word_t    q_imem,
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    input  word_t    q_dmem,
    output logic     ctrl_writeEnable,
    output reg_idx_t ctrl_writeReg,
    output reg_idx_t ctrl_readRegA,
    output reg_idx_t ctrl_readRegB,
    output word_t    data_writeReg,
    input  word_t    data_readRegA,
    input  word_t    data_readRegB
);

    // ----------------------------------------------------------
    // Stage to stage nets
    // ----------------------------------------------------------
    logic     stall, redirect;
    word_t    redirect_pc;
    word_t    fd_instr, fd_pc_plus1;
    logic     fd_valid;
    logic     dx_valid, dx_use_imm, dx_reg_write, dx_mem_write, dx_mem_to_reg;
    opcode_e  dx_op;
    alu_op_e  dx_alu_op;
    reg_idx_t dx_dest;
    shamt_t   dx_shamt;
    word_t    dx_a, dx_b, dx_imm, dx_target, dx_pc_plus1;
    word_t    xm_result, xm_store_data;
    reg_idx_t xm_dest, mw_dest;
    logic     xm_reg_write, xm_mem_write, xm_mem_to_reg, mw_reg_write;

    fetch_stage u_fetch (
        .clock, .reset, .stall, .redirect, .redirect_pc, .q_imem,
        .address_imem, .fd_instr, .fd_pc_plus1, .fd_valid
    );

    decode_stage u_decode (
        .clock, .reset, .fd_instr, .fd_pc_plus1, .fd_valid, .redirect,
        .data_readRegA, .data_readRegB,
        .dx_hold_dest (dx_dest),  // Execute slot destination for the interlock
        .xm_dest, .mw_dest, .xm_reg_write, .mw_reg_write,
        .stall, .ctrl_readRegA, .ctrl_readRegB,
        .dx_valid, .dx_op, .dx_alu_op, .dx_use_imm, .dx_reg_write, .dx_mem_write,
        .dx_mem_to_reg, .dx_dest, .dx_shamt, .dx_a, .dx_b, .dx_imm, .dx_target,
        .dx_pc_plus1
    );

    execute_stage u_execute (
        .clock, .reset,
        .dx_valid, .dx_op, .dx_alu_op, .dx_use_imm, .dx_reg_write, .dx_mem_write,
        .dx_mem_to_reg, .dx_dest, .dx_shamt, .dx_a, .dx_b, .dx_imm, .dx_target,
        .dx_pc_plus1,
        .redirect, .redirect_pc,
        .xm_result, .xm_store_data, .xm_dest, .xm_reg_write, .xm_mem_write,
        .xm_mem_to_reg
    );

    memory_writeback u_memwb (
        .clock, .reset,
        .xm_result, .xm_store_data, .xm_dest, .xm_reg_write, .xm_mem_write,
        .xm_mem_to_reg, .q_dmem,
        .address_dmem, .data, .wren, .mw_dest, .mw_reg_write,
        .ctrl_writeEnable, .ctrl_writeReg, .data_writeReg
    );

endmodule

`default_nettype wire

// ==== verif/processor_props.sv ====
// Concurrent assertions on processor port behavior, bound into processor
`default_nettype none

module processor_props import cpu_pkg::*; (
    input wire           clock,
    input wire           reset,
    input wire           stall,      // Decode interlock
    input wire           redirect,   // Taken branch or jump
    input wire           wren,
    input wire           ctrl_writeEnable,
    input wire reg_idx_t ctrl_writeReg,
    input wire word_t    address_imem
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_failures = 0;  // Failure count for the summary

    // ------------------------------------------------------------
    // Write strobes quiet in reset and on the first cycle after it
    // ------------------------------------------------------------
    a_quiet_after_reset: assert property (@(posedge clock)
        reset |=> !wren && !ctrl_writeEnable)
        else begin
            assert_failures++;
            $error("Write strobe high during or right after reset");
        end

    // r0 is never a writeback target
    a_no_r0_write: assert property (@(posedge clock) disable iff (reset)
        ctrl_writeEnable |-> ctrl_writeReg != '0)
        else begin
            assert_failures++;
            $error("Register file write to r0");
        end

    // Fetch address holds through a stall unless a redirect replaces it
    a_pc_holds: assert property (@(posedge clock) disable iff (reset)
        stall && !redirect |=> $stable(address_imem))
        else begin
            assert_failures++;
            $error("Fetch address moved during a stall");
        end

endmodule

bind processor processor_props u_props (
    .clock, .reset, .stall, .redirect, .wren,
    .ctrl_writeEnable, .ctrl_writeReg, .address_imem
);

`default_nettype wire

// ==== verif/processor_tb.sv ====
// Testbench for the five-stage pipeline with imem, dmem and register-file models
// Directed tests for ALU ops, memory, interlock, branches, jumps and reset timing
`default_nettype none

module processor_tb import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // Cycle budgets per test, the watchdog is derived from them
    localparam int alu_budget    = 30;
    localparam int mem_budget    = 30;
    localparam int chain_budget  = 40;
    localparam int branch_budget = 40;
    localparam int jump_budget   = 40;
    localparam int timing_budget = 12;
    localparam int reset_cycles  = 9;   // Entry edge plus eight edges held in reset
    localparam int total_cycles  = alu_budget + mem_budget + chain_budget + branch_budget
                                 + jump_budget + timing_budget + 5 + 6 * reset_cycles;
    localparam int watchdog_ns   = (total_cycles + 100) * 100;

    logic     clock;
    logic     reset;
    word_t    address_imem, q_imem, address_dmem, data, q_dmem;
    word_t    data_writeReg, data_readRegA, data_readRegB;
    logic     wren, ctrl_writeEnable;
    reg_idx_t ctrl_writeReg, ctrl_readRegA, ctrl_readRegB;

    word_t imem [0:255];
    word_t dmem [0:255];
    word_t regs [0:31];
    int    errors = 0;
    int    checks = 0;
    word_t rng    = 32'h66c8_bcf8;

    processor UUT (.*);

    // ------------------------------------------------------------
    // Clock and the memory and register-file models
    // ------------------------------------------------------------
    always #50 clock = ~clock;  // 100 ns period

    assign q_imem        = imem[address_imem[7:0]];  // Combinational reads
    assign q_dmem        = dmem[address_dmem[7:0]];
    assign data_readRegA = regs[ctrl_readRegA];
    assign data_readRegB = regs[ctrl_readRegB];

    always @(posedge clock) begin
        if (ctrl_writeEnable)
            regs[ctrl_writeReg] <= data_writeReg;
        if (wren)
            dmem[address_dmem[7:0]] <= data;
    end

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t sext17(input imm_t v);
        return {{15{v[16]}}, v};
    endfunction

    // Random value that one addi can load
    function automatic word_t random_imm();
        rng = xorshift32(rng);
        return sext17(rng[16:0]);
    endfunction

    function automatic word_t dmem_fill(input logic [7:0] addr);
        return 32'hd0d0_0000 | {24'b0, addr};
    endfunction

    // One place per step, the sign bit refills the top
    function automatic word_t shift_right_signed(input word_t v, input shamt_t n);
        word_t r;
        r = v;
        for (int i = 0; i < n; i++)
            r = {r[31], r[31:1]};
        return r;
    endfunction

    // Instruction encoders, one per format
    function automatic word_t encode_r(input alu_op_e f, input reg_idx_t rd,
                                       input reg_idx_t rs, input reg_idx_t rt,
                                       input shamt_t sh);
        return {op_rtype, rd, rs, rt, sh, f, 2'b00};
    endfunction

    function automatic word_t encode_i(input opcode_e op, input reg_idx_t rd,
                                       input reg_idx_t rs, input imm_t imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t encode_j(input opcode_e op, input logic [26:0] target);
        return {op, target};
    endfunction

    // ------------------------------------------------------------
    // Sequencing and check helpers
    // ------------------------------------------------------------
    task automatic start_test(input string name);
        $display("Test: %s", name);
        @(posedge clock);
        #1 reset = 1'b1;
        @(posedge clock);  // Last write strobes of the old program land here
        #1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;                // All zeros is add r0, a nop
            dmem[i] = dmem_fill(i[7:0]);
        end
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
    endtask

    task automatic release_reset();
        repeat (7) @(posedge clock);
        #1 reset = 1'b0;
    endtask

    task automatic put(input int addr, input word_t instr);
        imem[addr] = instr;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clock);
        @(negedge clock);  // Register writes of the last edge have settled
    endtask

    task automatic expect_word(input string label, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, label, got, exp);
        end
    endtask

    task automatic check_reg(input string test, input int n, input word_t exp);
        expect_word($sformatf("%s r%0d", test, n), regs[n], exp);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic alu_test();
        word_t  a, b;
        shamt_t sh;
        a = random_imm();
        b = random_imm();
        rng = xorshift32(rng);
        sh = rng[4:0];
        start_test("alu");
        put(0, encode_i(op_addi, 1, 0, a[16:0]));
        put(1, encode_i(op_addi, 2, 0, b[16:0]));
        put(2, encode_r(alu_add, 3, 1, 2, 0));   // Waits on r2
        put(3, encode_r(alu_sub, 4, 1, 2, 0));
        put(4, encode_r(alu_and, 5, 1, 2, 0));
        put(5, encode_r(alu_or,  6, 1, 2, 0));
        put(6, encode_r(alu_sll, 7, 1, 0, sh));
        put(7, encode_r(alu_sra, 8, 1, 0, sh));
        put(8, encode_r(alu_add, 0, 1, 2, 0));   // Write to r0 is dropped
        put(9, encode_j(op_j, 9));
        release_reset();
        run_cycles(alu_budget);
        check_reg("alu add", 3, a + b);
        check_reg("alu sub", 4, a - b);
        check_reg("alu and", 5, a & b);
        check_reg("alu or", 6, a | b);
        check_reg("alu sll", 7, a << sh);
        check_reg("alu sra", 8, shift_right_signed(a, sh));
        check_reg("alu r0", 0, '0);
    endtask

    task automatic mem_test();
        word_t base, off, val, addr;
        rng = xorshift32(rng);
        base = rng & 32'h7f;
        rng = xorshift32(rng);
        off = rng & 32'h3f;
        val = random_imm();
        addr = base + off;
        start_test("memory");
        put(0, encode_i(op_addi, 1, 0, base[16:0]));
        put(1, encode_i(op_addi, 2, 0, val[16:0]));
        put(2, encode_i(op_sw, 2, 1, off[16:0]));   // dmem[r1 + off] = r2
        put(3, encode_i(op_lw, 3, 1, off[16:0]));
        put(4, encode_j(op_j, 4));
        release_reset();
        run_cycles(mem_budget);
        expect_word("memory stored word", dmem[addr[7:0]], val);
        expect_word("memory next word", dmem[addr[7:0] + 8'd1], dmem_fill(addr[7:0] + 8'd1));
        check_reg("memory load", 3, val);
    endtask

    task automatic chain_test();
        word_t k, sum;
        sum = '0;
        start_test("dependency chain");
        for (int i = 0; i < 6; i++) begin
            k = random_imm();
            sum = sum + k;
            put(i, encode_i(op_addi, 1, (i == 0) ? 5'd0 : 5'd1, k[16:0]));  // Each waits on r1
        end
        put(6, encode_j(op_j, 6));
        release_reset();
        run_cycles(chain_budget);
        check_reg("chain sum", 1, sum);
    endtask

    task automatic branch_test();
        start_test("branches");
        put(0,  encode_i(op_addi, 1, 0, imm_t'(-4)));
        put(1,  encode_i(op_addi, 2, 0, 9));
        put(2,  encode_i(op_bne,  1, 2, 2));      // Taken, skips 3 and 4
        put(3,  encode_i(op_addi, 10, 0, 'h10));
        put(4,  encode_i(op_addi, 11, 0, 'h11));
        put(5,  encode_i(op_bne,  1, 1, 2));      // Not taken
        put(6,  encode_i(op_addi, 12, 0, 'h12));
        put(7,  encode_i(op_addi, 13, 0, 'h13));
        put(8,  encode_i(op_blt,  1, 2, 2));      // Signed -4 < 9, taken
        put(9,  encode_i(op_addi, 14, 0, 'h14));
        put(10, encode_i(op_addi, 15, 0, 'h15));
        put(11, encode_i(op_blt,  2, 1, 2));      // Not taken
        put(12, encode_i(op_addi, 16, 0, 'h16));
        put(13, encode_i(op_addi, 17, 0, 'h17));
        put(14, encode_j(op_j, 14));
        release_reset();
        run_cycles(branch_budget);
        check_reg("bne taken", 10, '0);
        check_reg("bne taken", 11, '0);
        check_reg("bne not taken", 12, 'h12);
        check_reg("bne not taken", 13, 'h13);
        check_reg("blt taken", 14, '0);
        check_reg("blt taken", 15, '0);
        check_reg("blt not taken", 16, 'h16);
        check_reg("blt not taken", 17, 'h17);
    endtask

    task automatic jump_test();
        start_test("jumps");
        put(0,  encode_i(op_addi, 1, 0, 7));
        put(1,  encode_j(op_j, 4));
        put(2,  encode_i(op_addi, 2, 0, 1));      // Skipped by j
        put(3,  encode_i(op_addi, 3, 0, 1));
        put(4,  encode_j(op_jal, 8));             // Link is 5
        put(5,  encode_i(op_addi, 4, 0, 'h44));   // Runs after the return
        put(6,  encode_j(op_j, 6));
        put(8,  encode_i(op_addi, 5, 0, 'h55));
        put(9,  encode_i(op_jr, 31, 0, 0));       // Returns through r31 from jal
        put(10, encode_i(op_addi, 6, 0, 1));
        put(11, encode_i(op_addi, 7, 0, 1));
        release_reset();
        run_cycles(jump_budget);
        check_reg("j before", 1, 7);
        check_reg("j skipped", 2, '0);
        check_reg("j skipped", 3, '0);
        check_reg("jal link", 31, 5);
        check_reg("jal target", 5, 'h55);
        check_reg("jr return", 4, 'h44);
        check_reg("jr skipped", 6, '0);
        check_reg("jr skipped", 7, '0);
    endtask

    task automatic timing_test();
        start_test("reset and latency");
        put(0, encode_i(op_addi, 1, 0, 1));
        put(1, encode_i(op_addi, 2, 0, 2));
        put(2, encode_i(op_addi, 3, 0, 3));
        put(3, encode_j(op_j, 3));
        release_reset();
        @(negedge clock);                         // Fetch cycle of address 0
        expect_word("first fetch address", address_imem, '0);
        for (int k = 1; k <= 4; k++) begin
            @(negedge clock);
            expect_word($sformatf("write enable %0d cycles after fetch", k),
                        {31'b0, ctrl_writeEnable}, (k == 4) ? 32'd1 : 32'd0);
        end
        expect_word("first write register", {27'b0, ctrl_writeReg}, 1);
        expect_word("first write data", data_writeReg, 1);
        run_cycles(timing_budget);
        check_reg("latency", 2, 2);
        check_reg("latency", 3, 3);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        clock = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = dmem_fill(i[7:0]);
        end
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        alu_test();
        mem_test();
        chain_test();
        branch_test();
        jump_test();
        timing_test();
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_props.assert_failures);
        if (errors == 0 && UUT.u_props.assert_failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
